//--- i2c_target_params.svh
/*
  Width constants for the I2C target. The byte and address widths follow
  the I2C standard and are not meant to be changed. The hold count width
  bounds the largest thd_dat_i value that software can program.
*/
`ifndef I2C_TARGET_PARAMS_SVH
`define I2C_TARGET_PARAMS_SVH

// Data byte on the wire
`define I2C_BYTE_W 8

// Seven-bit target address, no ten-bit addressing
`define I2C_ADDR_W 7

// Hold time count in system clock cycles
`define I2C_HOLD_W 16

// Bit index runs 0 to 8, where index 8 is the ACK slot
`define I2C_BIT_IDX_W 4

`endif

//--- i2c_target_pkg.sv
/*
  Shared types of the I2C target. The FSM state list has no clock
  stretching or NACK states, because the target never stretches SCL and
  always acknowledges a matched address and every written byte.
*/
`include "i2c_target_params.svh"

package i2c_target_pkg;

  //////////////////////////////////////////////////////////////////////
  // Acquisition entries
  //////////////////////////////////////////////////////////////////////

  // Kind tag of each entry strobed out on the acquisition port
  typedef enum logic [1:0] {
    AcqStart   = 2'd0,
    AcqData    = 2'd1,
    AcqRestart = 2'd2,
    AcqStop    = 2'd3
  } acq_kind_e;

  // The byte is the address byte for a Start, else the last received byte
  typedef struct packed {
    acq_kind_e               kind;
    logic [`I2C_BYTE_W-1:0]  data;
  } acq_entry_t;

  // Two address and mask pairs, a bit set in a mask takes part in the match
  typedef struct packed {
    logic [`I2C_ADDR_W-1:0] addr0;
    logic [`I2C_ADDR_W-1:0] mask0;
    logic [`I2C_ADDR_W-1:0] addr1;
    logic [`I2C_ADDR_W-1:0] mask1;
  } addr_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // Internal links between the blocks
  //////////////////////////////////////////////////////////////////////

  // One-cycle bus events from the monitor, sda is the live level
  typedef struct packed {
    logic scl_rise;
    logic scl_fall;
    logic start_det;
    logic stop_det;
    logic sda;
  } bus_evt_t;

  // Shifter state as seen by the FSM
  typedef struct packed {
    logic [`I2C_BYTE_W-1:0]    rx_byte;
    logic [`I2C_BIT_IDX_W-1:0] bit_idx;
    logic                      bit_ack;
    logic                      host_ack;
  } rx_stat_t;

  // Target protocol states
  typedef enum logic [4:0] {
    Idle,
    AcquireStart,
    AddrRead,
    AddrAckWait,
    AddrAckSetup,
    AddrAckPulse,
    AddrAckHold,
    TransmitWait,
    TransmitSetup,
    TransmitPulse,
    TransmitHold,
    TransmitAck,
    TransmitAckPulse,
    WaitForStop,
    AcquireByte,
    AcquireAckWait,
    AcquireAckSetup,
    AcquireAckPulse,
    AcquireAckHold
  } tgt_state_e;

endpackage

//--- i2c_bus_monitor.sv
/*
  SCL and SDA must already be synchronized to clk_i. A Start or Stop is
  reported only after SCL stays high for thd_dat_i cycles past the SDA
  edge, and a hold count of 0 acts as 1.
*/
`timescale 1ns/1ps
`include "i2c_target_params.svh"

module i2c_bus_monitor (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scl_i,
  input  logic                     sda_i,
  input  logic                     target_enable_i,
  input  logic [`I2C_HOLD_W-1:0]   thd_dat_i,
  output i2c_target_pkg::bus_evt_t bus_evt_o
);

  logic                   scl_q;
  logic                   sda_q;
  logic                   start_trigger;
  logic                   stop_trigger;
  logic                   start_pending;
  logic                   stop_pending;
  logic                   start_det;
  logic                   stop_det;
  logic [`I2C_HOLD_W-1:0] ctrl_det_count;

  // Previous samples, an idle bus reads high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
    end
  end

  // SDA moving while SCL is high on both samples is a control symbol candidate
  assign start_trigger = target_enable_i && scl_q && scl_i && sda_q && !sda_i;
  assign stop_trigger  = target_enable_i && scl_q && scl_i && !sda_q && sda_i;

  //////////////////////////////////////////////////////////////////////
  // Control symbol qualification
  //////////////////////////////////////////////////////////////////////

  // One counter serves both kinds, as only one can be pending at a time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_det_count <= '0;
    end else if (start_trigger || stop_trigger) begin
      ctrl_det_count <= `I2C_HOLD_W'(1);
    end else if (start_pending || stop_pending) begin
      ctrl_det_count <= ctrl_det_count + 1'b1;
    end
  end

  // An SCL fall before the count expires means the SDA edge was early data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pending <= 1'b0;
      stop_pending  <= 1'b0;
    end else begin
      if (start_trigger) begin
        start_pending <= 1'b1;
      end else if (!target_enable_i || !scl_i || start_det || stop_trigger) begin
        start_pending <= 1'b0;
      end
      if (stop_trigger) begin
        stop_pending <= 1'b1;
      end else if (!target_enable_i || !scl_i || stop_det || start_trigger) begin
        stop_pending <= 1'b0;
      end
    end
  end

  assign start_det = target_enable_i && scl_i && start_pending &&
                     (ctrl_det_count >= thd_dat_i);
  assign stop_det  = target_enable_i && scl_i && stop_pending &&
                     (ctrl_det_count >= thd_dat_i);

  // Edges show up in the same cycle that the input first differs
  assign bus_evt_o.scl_rise  = scl_i && !scl_q;
  assign bus_evt_o.scl_fall  = !scl_i && scl_q;
  assign bus_evt_o.start_det = start_det;
  assign bus_evt_o.stop_det  = stop_det;
  assign bus_evt_o.sda       = sda_i;

endmodule

//--- i2c_byte_shifter.sv
/*
  Bit counter and receive shift register. Bits are taken MSB first on SCL
  rises, and the ACK slot rise captures the host's ACK instead of data.
*/
`timescale 1ns/1ps
`include "i2c_target_params.svh"

module i2c_byte_shifter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i2c_target_pkg::bus_evt_t bus_evt_i,
  input  logic                     byte_clr_i,
  output i2c_target_pkg::rx_stat_t rx_stat_o
);

  logic [`I2C_BIT_IDX_W-1:0] bit_idx;
  logic [`I2C_BYTE_W-1:0]    rx_byte;
  logic                      bit_ack;
  logic                      host_ack;

  // The slot after the eighth data bit carries the ACK
  assign bit_ack = (bit_idx == `I2C_BIT_IDX_W'(`I2C_BYTE_W));

  // Index moves on the falling edge, so it names the bit SCL will rise on next
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx <= '0;
    end else if (bus_evt_i.start_det || byte_clr_i) begin
      bit_idx <= '0;
    end else if (bus_evt_i.scl_fall) begin
      if (bit_ack) begin
        bit_idx <= '0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // Data shifts in MSB first and is left alone during the ACK slot
  always_ff @(posedge clk_i) begin
    if (byte_clr_i) begin
      rx_byte <= '0;
    end else if (bus_evt_i.scl_rise && !bit_ack) begin
      rx_byte <= {rx_byte[`I2C_BYTE_W-2:0], bus_evt_i.sda};
    end
  end

  // A low SDA in the ACK slot is an ACK from the host
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack <= 1'b0;
    end else if (bus_evt_i.scl_rise && bit_ack) begin
      host_ack <= ~bus_evt_i.sda;
    end
  end

  assign rx_stat_o.rx_byte  = rx_byte;
  assign rx_stat_o.bit_idx  = bit_idx;
  assign rx_stat_o.bit_ack  = bit_ack;
  assign rx_stat_o.host_ack = host_ack;

endmodule

//--- i2c_target_fsm.sv
/*
  Target protocol FSM. SCL is never stretched, so every matched address and
  every written byte is ACKed and acquisition entries have no back-pressure.
  A read that finds tx_valid_i low sends 0xFF, which leaves SDA released.
*/
`timescale 1ns/1ps
`include "i2c_target_params.svh"

module i2c_target_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       target_enable_i,
  input  i2c_target_pkg::addr_cfg_t  addr_cfg_i,
  input  logic [`I2C_HOLD_W-1:0]     thd_dat_i,
  input  i2c_target_pkg::bus_evt_t   bus_evt_i,
  input  i2c_target_pkg::rx_stat_t   rx_stat_i,
  input  logic                       tx_valid_i,
  input  logic [`I2C_BYTE_W-1:0]     tx_data_i,
  output logic                       byte_clr_o,
  output logic                       sda_o,
  output logic                       acq_valid_o,
  output i2c_target_pkg::acq_entry_t acq_entry_o,
  output logic                       tx_pop_o,
  output logic                       cmd_complete_o,
  output logic                       unexp_stop_o,
  output logic                       sr_p_cond_o,
  output logic                       target_idle_o
);

  i2c_target_pkg::tgt_state_e state_q;
  i2c_target_pkg::tgt_state_e state_d;

  logic [`I2C_HOLD_W-1:0] tcount_q;
  logic [`I2C_HOLD_W-1:0] hold_load;
  logic                   load_tcount;
  logic                   hold_done;
  logic                   scl_low_q;
  logic                   scl_low;
  logic                   addr_match;
  logic                   rw_q;
  logic [`I2C_BYTE_W-1:0] tx_rev;
  logic [`I2C_BYTE_W-1:0] tx_byte_q;
  logic                   sda_d;
  logic                   sda_q;
  logic                   ctrl_det;

  assign target_idle_o = (state_q == i2c_target_pkg::Idle);
  assign ctrl_det      = bus_evt_i.start_det || bus_evt_i.stop_det;

  //////////////////////////////////////////////////////////////////////
  // Hold counter and SCL level
  //////////////////////////////////////////////////////////////////////

  // Loaded with the hold count, then counts down and rests at 1
  assign hold_load = (thd_dat_i == '0) ? `I2C_HOLD_W'(1) : thd_dat_i;
  assign hold_done = (tcount_q == `I2C_HOLD_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tcount_q <= `I2C_HOLD_W'(1);
    end else if (load_tcount) begin
      tcount_q <= hold_load;
    end else if (tcount_q > `I2C_HOLD_W'(1)) begin
      tcount_q <= tcount_q - 1'b1;
    end
  end

  // The monitor only passes edges, so the SCL level is rebuilt from them
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_low_q <= 1'b0;
    end else if (bus_evt_i.scl_fall) begin
      scl_low_q <= 1'b1;
    end else if (bus_evt_i.scl_rise) begin
      scl_low_q <= 1'b0;
    end
  end

  assign scl_low = bus_evt_i.scl_fall || (scl_low_q && !bus_evt_i.scl_rise);

  //////////////////////////////////////////////////////////////////////
  // Address match and transmit byte
  //////////////////////////////////////////////////////////////////////

  // Address sits in the upper seven bits, the read/write bit in bit 0
  assign addr_match =
    ((rx_stat_i.rx_byte[`I2C_BYTE_W-1:1] & addr_cfg_i.mask0) == addr_cfg_i.addr0) ||
    ((rx_stat_i.rx_byte[`I2C_BYTE_W-1:1] & addr_cfg_i.mask1) == addr_cfg_i.addr1);

  // High for a host read, kept until the next matched address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rw_q <= 1'b0;
    end else if (state_q == i2c_target_pkg::AddrRead && rx_stat_i.bit_ack && addr_match) begin
      rw_q <= rx_stat_i.rx_byte[0];
    end
  end

  // Reversed so that bit index 0 picks the MSB
  assign tx_rev = {<<{tx_data_i}};

  always_ff @(posedge clk_i) begin
    if (state_q == i2c_target_pkg::TransmitWait) begin
      tx_byte_q <= tx_valid_i ? tx_rev : '1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    load_tcount = 1'b0;
    byte_clr_o  = 1'b0;
    unique case (state_q)
      // First SCL fall after the Start begins the address byte
      i2c_target_pkg::AcquireStart: begin
        if (bus_evt_i.scl_fall) begin
          state_d    = i2c_target_pkg::AddrRead;
          byte_clr_o = 1'b1;
        end
      end
      // Not our address means we stay off the bus until the next Start
      i2c_target_pkg::AddrRead: begin
        if (rx_stat_i.bit_ack) begin
          if (addr_match) begin
            state_d     = i2c_target_pkg::AddrAckWait;
            load_tcount = 1'b1;
          end else begin
            state_d = i2c_target_pkg::Idle;
          end
        end
      end
      i2c_target_pkg::AddrAckWait: begin
        if (hold_done && scl_low) begin
          state_d = i2c_target_pkg::AddrAckSetup;
        end
      end
      i2c_target_pkg::AddrAckSetup: begin
        if (bus_evt_i.scl_rise) begin
          state_d = i2c_target_pkg::AddrAckPulse;
        end
      end
      i2c_target_pkg::AddrAckPulse: begin
        if (bus_evt_i.scl_fall) begin
          state_d     = i2c_target_pkg::AddrAckHold;
          load_tcount = 1'b1;
        end
      end
      i2c_target_pkg::AddrAckHold: begin
        if (hold_done) begin
          state_d = rw_q ? i2c_target_pkg::TransmitWait : i2c_target_pkg::AcquireByte;
        end
      end
      // One cycle to latch the byte, or 0xFF when none is ready
      i2c_target_pkg::TransmitWait: begin
        state_d = i2c_target_pkg::TransmitSetup;
      end
      i2c_target_pkg::TransmitSetup: begin
        if (bus_evt_i.scl_rise) begin
          state_d = i2c_target_pkg::TransmitPulse;
        end
      end
      i2c_target_pkg::TransmitPulse: begin
        if (bus_evt_i.scl_fall) begin
          state_d     = i2c_target_pkg::TransmitHold;
          load_tcount = 1'b1;
        end
      end
      // Bit stays on SDA for the hold time, then the next bit or the ACK slot
      i2c_target_pkg::TransmitHold: begin
        if (hold_done) begin
          if (rx_stat_i.bit_ack) begin
            state_d = i2c_target_pkg::TransmitAck;
          end else begin
            state_d = i2c_target_pkg::TransmitSetup;
          end
        end
      end
      i2c_target_pkg::TransmitAck: begin
        if (bus_evt_i.scl_rise) begin
          state_d = i2c_target_pkg::TransmitAckPulse;
        end
      end
      // A NACK from the host ends the read, only a Stop or Start follows
      i2c_target_pkg::TransmitAckPulse: begin
        if (bus_evt_i.scl_fall) begin
          if (rx_stat_i.host_ack) begin
            state_d = i2c_target_pkg::TransmitWait;
          end else begin
            state_d = i2c_target_pkg::WaitForStop;
          end
        end
      end
      i2c_target_pkg::WaitForStop: begin
        state_d = i2c_target_pkg::WaitForStop;
      end
      i2c_target_pkg::AcquireByte: begin
        if (rx_stat_i.bit_ack) begin
          state_d     = i2c_target_pkg::AcquireAckWait;
          load_tcount = 1'b1;
        end
      end
      i2c_target_pkg::AcquireAckWait: begin
        if (hold_done && scl_low) begin
          state_d = i2c_target_pkg::AcquireAckSetup;
        end
      end
      i2c_target_pkg::AcquireAckSetup: begin
        if (bus_evt_i.scl_rise) begin
          state_d = i2c_target_pkg::AcquireAckPulse;
        end
      end
      i2c_target_pkg::AcquireAckPulse: begin
        if (bus_evt_i.scl_fall) begin
          state_d     = i2c_target_pkg::AcquireAckHold;
          load_tcount = 1'b1;
        end
      end
      i2c_target_pkg::AcquireAckHold: begin
        if (hold_done) begin
          state_d = i2c_target_pkg::AcquireByte;
        end
      end
      default: begin
        state_d = i2c_target_pkg::Idle;
      end
    endcase

    // Disable wins over bus symbols, and a Start always restarts the FSM
    if (!target_idle_o && !target_enable_i) begin
      state_d = i2c_target_pkg::Idle;
    end else if (bus_evt_i.start_det) begin
      state_d = i2c_target_pkg::AcquireStart;
    end else if (bus_evt_i.stop_det) begin
      state_d = i2c_target_pkg::Idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i2c_target_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sda_d            = 1'b1;
    acq_valid_o      = 1'b0;
    acq_entry_o.kind = i2c_target_pkg::AcqData;
    acq_entry_o.data = rx_stat_i.rx_byte;
    tx_pop_o         = 1'b0;
    cmd_complete_o   = 1'b0;
    unique case (state_q)
      i2c_target_pkg::AddrAckSetup, i2c_target_pkg::AddrAckPulse,
      i2c_target_pkg::AcquireAckSetup, i2c_target_pkg::AcquireAckPulse: begin
        sda_d = 1'b0;
      end
      // Entry goes out on the last cycle of the ACK hold
      i2c_target_pkg::AddrAckHold: begin
        sda_d            = 1'b0;
        acq_valid_o      = hold_done;
        acq_entry_o.kind = i2c_target_pkg::AcqStart;
      end
      i2c_target_pkg::AcquireAckHold: begin
        sda_d       = 1'b0;
        acq_valid_o = hold_done;
      end
      i2c_target_pkg::TransmitSetup: begin
        sda_d = tx_byte_q[rx_stat_i.bit_idx[2:0]];
      end
      i2c_target_pkg::TransmitPulse, i2c_target_pkg::TransmitHold: begin
        sda_d = sda_q;
      end
      // Pop on the fall that ends the ACK slot, whatever the host answered
      i2c_target_pkg::TransmitAckPulse: begin
        tx_pop_o = bus_evt_i.scl_fall;
      end
      default: begin
        sda_d = 1'b1;
      end
    endcase

    // Restart and Stop are only logged when a transaction was in progress
    if (ctrl_det) begin
      acq_valid_o      = !target_idle_o;
      acq_entry_o.kind = bus_evt_i.start_det ? i2c_target_pkg::AcqRestart
                                             : i2c_target_pkg::AcqStop;
      cmd_complete_o   = !target_idle_o;
    end
  end

  // Last driven SDA value, held while SCL is high and through the hold time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_q <= 1'b1;
    end else begin
      sda_q <= sda_d;
    end
  end

  assign sda_o = sda_d;

  // A Stop during a read is expected only after the host has NACKed
  assign unexp_stop_o = !target_idle_o && rw_q && bus_evt_i.stop_det &&
                        (state_q != i2c_target_pkg::WaitForStop);

  // Software can use this to flush transmit data meant for the old command
  assign sr_p_cond_o = target_enable_i && !target_idle_o && ctrl_det;

endmodule

//--- i2c_target_top.sv
/*
  I2C target top level. SCL is input only since the target never stretches.
  sda_o is an open-drain enable, low pulls the bus low. The receiver of the
  acquisition port must take each entry in the cycle acq_valid_o is high.
*/
`timescale 1ns/1ps
`include "i2c_target_params.svh"

module i2c_target_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  logic                       target_enable_i,
  input  i2c_target_pkg::addr_cfg_t  addr_cfg_i,
  input  logic [`I2C_HOLD_W-1:0]     thd_dat_i,
  input  logic                       tx_valid_i,
  input  logic [`I2C_BYTE_W-1:0]     tx_data_i,
  output logic                       sda_o,
  output logic                       acq_valid_o,
  output i2c_target_pkg::acq_entry_t acq_entry_o,
  output logic                       tx_pop_o,
  output logic                       cmd_complete_o,
  output logic                       unexp_stop_o,
  output logic                       sr_p_cond_o,
  output logic                       target_idle_o
);

  i2c_target_pkg::bus_evt_t bus_evt;
  i2c_target_pkg::rx_stat_t rx_stat;
  logic                     byte_clr;

  // Edge and Start/Stop detection on the raw bus lines
  i2c_bus_monitor u_bus_monitor (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .target_enable_i (target_enable_i),
    .thd_dat_i       (thd_dat_i),
    .bus_evt_o       (bus_evt)
  );

  // Bit counting and byte assembly, cleared by the FSM at the address byte
  i2c_byte_shifter u_byte_shifter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus_evt_i  (bus_evt),
    .byte_clr_i (byte_clr),
    .rx_stat_o  (rx_stat)
  );

  i2c_target_fsm u_target_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .target_enable_i (target_enable_i),
    .addr_cfg_i      (addr_cfg_i),
    .thd_dat_i       (thd_dat_i),
    .bus_evt_i       (bus_evt),
    .rx_stat_i       (rx_stat),
    .tx_valid_i      (tx_valid_i),
    .tx_data_i       (tx_data_i),
    .byte_clr_o      (byte_clr),
    .sda_o           (sda_o),
    .acq_valid_o     (acq_valid_o),
    .acq_entry_o     (acq_entry_o),
    .tx_pop_o        (tx_pop_o),
    .cmd_complete_o  (cmd_complete_o),
    .unexp_stop_o    (unexp_stop_o),
    .sr_p_cond_o     (sr_p_cond_o),
    .target_idle_o   (target_idle_o)
  );

endmodule

//--- tb_i2c_host_tasks.svh
/*
  Bit-banged I2C host tasks for the testbench. They expect scl_h, sda_h,
  sda_bus and clk_i in the enclosing module. Each SCL phase lasts 20 clocks
  and the host only moves SDA in the middle of the low phase.
*/
`ifndef TB_I2C_HOST_TASKS_SVH
`define TB_I2C_HOST_TASKS_SVH

// Step n rising edges, then move 1 ns past the edge before driving
task automatic wait_clks(input int n);
  repeat (n) @(posedge clk_i);
  #1;
endtask

// Works from an idle bus and as a repeated Start after an ACK slot
task automatic send_start();
  scl_h = 1'b0;
  wait_clks(10);
  sda_h = 1'b1;
  wait_clks(10);
  scl_h = 1'b1;
  wait_clks(20);
  // SDA falls while SCL is high
  sda_h = 1'b0;
  wait_clks(20);
endtask

task automatic send_stop();
  scl_h = 1'b0;
  wait_clks(10);
  sda_h = 1'b0;
  wait_clks(10);
  scl_h = 1'b1;
  wait_clks(20);
  // SDA rises while SCL is high
  sda_h = 1'b1;
  wait_clks(20);
endtask

// One bit driven by the host, SCL ends high
task automatic put_bit(input logic b);
  scl_h = 1'b0;
  wait_clks(10);
  sda_h = b;
  wait_clks(10);
  scl_h = 1'b1;
  wait_clks(20);
endtask

// Host releases SDA and samples the bus in the middle of the high phase
task automatic get_bit(output logic b);
  scl_h = 1'b0;
  wait_clks(10);
  sda_h = 1'b1;
  wait_clks(10);
  scl_h = 1'b1;
  wait_clks(10);
  b = sda_bus;
  wait_clks(10);
endtask

// MSB first, ack_bit is the SDA level seen in the ACK slot
task automatic write_byte(input logic [7:0] b, output logic ack_bit);
  for (int i = 7; i >= 0; i--) begin
    put_bit(b[i]);
  end
  get_bit(ack_bit);
endtask

// A low bit in the ACK slot asks the target for another byte
task automatic read_byte(output logic [7:0] b, input logic host_ack);
  logic bit_v;
  for (int i = 7; i >= 0; i--) begin
    get_bit(bit_v);
    b[i] = bit_v;
  end
  put_bit(!host_ack);
endtask

`endif

//--- tb_i2c_target.sv
/*
  Directed testbench for the I2C target. The bus SDA is the wired AND of
  the host and the target, and SCL is driven by the host alone. Entries
  strobed on the acquisition port are queued and checked after each test.
*/
`timescale 1ns/1ps
`include "i2c_target_params.svh"

module tb_i2c_target;

  // Six tests of up to six bytes each, and a byte is nine bits of 40 clocks
  localparam int unsigned NUM_TESTS      = 6;
  localparam int unsigned BYTES_PER_TEST = 6;
  localparam int unsigned CLKS_PER_BYTE  = 9 * 40;
  localparam int unsigned WATCHDOG_CLKS  = NUM_TESTS * BYTES_PER_TEST * CLKS_PER_BYTE * 2;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       scl_h;
  logic                       sda_h;
  logic                       sda_bus;
  logic                       target_enable;
  i2c_target_pkg::addr_cfg_t  addr_cfg;
  logic [`I2C_HOLD_W-1:0]     thd_dat;
  logic                       tx_valid;
  logic [`I2C_BYTE_W-1:0]     tx_data;
  logic                       sda_o;
  logic                       acq_valid;
  i2c_target_pkg::acq_entry_t acq_entry;
  logic                       tx_pop;
  logic                       cmd_complete;
  logic                       unexp_stop;
  logic                       sr_p_cond;
  logic                       target_idle;

  logic [9:0]  acq_q[$];
  int          cmd_count;
  int          srp_count;
  int          unexp_count;
  int          pop_count;
  int unsigned rng_state;

  // Either side can pull the open-drain SDA low
  assign sda_bus = sda_h & sda_o;

  i2c_target_top uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scl_i           (scl_h),
    .sda_i           (sda_bus),
    .target_enable_i (target_enable),
    .addr_cfg_i      (addr_cfg),
    .thd_dat_i       (thd_dat),
    .tx_valid_i      (tx_valid),
    .tx_data_i       (tx_data),
    .sda_o           (sda_o),
    .acq_valid_o     (acq_valid),
    .acq_entry_o     (acq_entry),
    .tx_pop_o        (tx_pop),
    .cmd_complete_o  (cmd_complete),
    .unexp_stop_o    (unexp_stop),
    .sr_p_cond_o     (sr_p_cond),
    .target_idle_o   (target_idle)
  );

  `include "tb_i2c_host_tasks.svh"

  initial begin
    clk_i = 1'b0;
  end

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("ERROR @%0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Pops the oldest entry and skips the data for Restart and Stop
  task automatic expect_entry(input i2c_target_pkg::acq_kind_e kind,
                              input logic [7:0] data, input logic check_data);
    logic [9:0] e;
    if (acq_q.size() == 0) begin
      $display("An acquisition entry was expected at %0t but none was strobed", $time);
      $display("TB FAILED");
      $fatal(1);
    end
    e = acq_q.pop_front();
    check_value(32'(e[9:8]), 32'(kind), "entry kind");
    if (check_data) begin
      check_value(32'(e[7:0]), 32'(data), "entry data");
    end
  endtask

  task automatic clear_counts();
    acq_q.delete();
    cmd_count   = 0;
    srp_count   = 0;
    unexp_count = 0;
    pop_count   = 0;
  endtask

  // The data byte comes from the middle bits of a plain LCG
  function automatic logic [7:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[23:16];
  endfunction

  // Sampled at the falling edge where the combinational strobes are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (acq_valid) begin
        acq_q.push_back({acq_entry.kind, acq_entry.data});
      end
      cmd_count   = cmd_count + int'(cmd_complete);
      srp_count   = srp_count + int'(sr_p_cond);
      unexp_count = unexp_count + int'(unexp_stop);
      pop_count   = pop_count + int'(tx_pop);
    end
  end

  initial begin
    repeat (WATCHDOG_CLKS) @(posedge clk_i);
    $display("Timeout, the tests did not finish within %0d clocks", WATCHDOG_CLKS);
    $display("TB FAILED");
    $fatal(1);
  end

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic write_to_addr0();
    logic [7:0] d0;
    logic [7:0] d1;
    logic       ack;
    clear_counts();
    d0 = next_rand();
    d1 = next_rand();
    send_start();
    write_byte({7'h3A, 1'b0}, ack);
    check_value(32'(ack), 0, "address ACK");
    write_byte(d0, ack);
    check_value(32'(ack), 0, "data ACK 0");
    write_byte(d1, ack);
    check_value(32'(ack), 0, "data ACK 1");
    send_stop();
    expect_entry(i2c_target_pkg::AcqStart, {7'h3A, 1'b0}, 1'b1);
    expect_entry(i2c_target_pkg::AcqData, d0, 1'b1);
    expect_entry(i2c_target_pkg::AcqData, d1, 1'b1);
    expect_entry(i2c_target_pkg::AcqStop, 8'h00, 1'b0);
    check_value(acq_q.size(), 0, "extra entries");
    check_value(cmd_count, 1, "cmd_complete pulses");
    check_value(srp_count, 1, "sr_p_cond pulses");
  endtask

  // 0x52 differs from addr1 only in bit 1, which mask1 leaves out
  task automatic masked_match_restart();
    logic [7:0] d0;
    logic [7:0] d1;
    logic       ack;
    clear_counts();
    d0 = next_rand();
    d1 = next_rand();
    send_start();
    write_byte({7'h52, 1'b0}, ack);
    check_value(32'(ack), 0, "masked address ACK");
    write_byte(d0, ack);
    check_value(32'(ack), 0, "data ACK");
    send_start();
    write_byte({7'h3A, 1'b0}, ack);
    check_value(32'(ack), 0, "address ACK after restart");
    write_byte(d1, ack);
    check_value(32'(ack), 0, "data ACK after restart");
    send_stop();
    expect_entry(i2c_target_pkg::AcqStart, {7'h52, 1'b0}, 1'b1);
    expect_entry(i2c_target_pkg::AcqData, d0, 1'b1);
    expect_entry(i2c_target_pkg::AcqRestart, 8'h00, 1'b0);
    expect_entry(i2c_target_pkg::AcqStart, {7'h3A, 1'b0}, 1'b1);
    expect_entry(i2c_target_pkg::AcqData, d1, 1'b1);
    expect_entry(i2c_target_pkg::AcqStop, 8'h00, 1'b0);
    check_value(acq_q.size(), 0, "extra entries");
    check_value(cmd_count, 2, "cmd_complete pulses");
    check_value(srp_count, 2, "sr_p_cond pulses");
  endtask

  task automatic addr_mismatch();
    logic ack;
    clear_counts();
    send_start();
    write_byte({7'h11, 1'b0}, ack);
    check_value(32'(ack), 1, "mismatch ACK slot");
    check_value(32'(target_idle), 1, "idle after mismatch");
    send_stop();
    check_value(acq_q.size(), 0, "entries after mismatch");
    check_value(cmd_count, 0, "cmd_complete pulses");
  endtask

  task automatic read_two_bytes();
    logic [7:0] exp0;
    logic [7:0] exp1;
    logic [7:0] got;
    logic       ack;
    clear_counts();
    exp0     = next_rand();
    exp1     = next_rand();
    tx_valid = 1'b1;
    tx_data  = exp0;
    send_start();
    write_byte({7'h3A, 1'b1}, ack);
    check_value(32'(ack), 0, "read address ACK");
    read_byte(got, 1'b1);
    check_value(32'(got), 32'(exp0), "read byte 0");
    // The FSM takes the next byte just after the fall that ends this ACK slot
    tx_data = exp1;
    read_byte(got, 1'b0);
    check_value(32'(got), 32'(exp1), "read byte 1");
    send_stop();
    tx_valid = 1'b0;
    check_value(pop_count, 2, "tx_pop pulses");
    check_value(unexp_count, 0, "unexp_stop pulses");
    expect_entry(i2c_target_pkg::AcqStart, {7'h3A, 1'b1}, 1'b1);
    expect_entry(i2c_target_pkg::AcqStop, 8'h00, 1'b0);
    check_value(acq_q.size(), 0, "extra entries");
    check_value(cmd_count, 1, "cmd_complete pulses");
  endtask

  task automatic read_empty_unexp_stop();
    logic [7:0] got;
    logic       ack;
    clear_counts();
    tx_valid = 1'b0;
    send_start();
    write_byte({7'h3A, 1'b1}, ack);
    check_value(32'(ack), 0, "read address ACK");
    read_byte(got, 1'b1);
    check_value(32'(got), 32'hFF, "empty read byte");
    send_stop();
    check_value(pop_count, 1, "tx_pop pulses");
    check_value(unexp_count, 1, "unexp_stop pulses");
  endtask

  task automatic disable_mid_write();
    logic [7:0] d0;
    logic [7:0] d1;
    logic       ack;
    clear_counts();
    d0 = next_rand();
    d1 = next_rand();
    send_start();
    write_byte({7'h3A, 1'b0}, ack);
    write_byte(d0, ack);
    for (int i = 7; i >= 4; i--) begin
      put_bit(d1[i]);
    end
    target_enable = 1'b0;
    wait_clks(2);
    check_value(32'(target_idle), 1, "idle after disable");
    for (int i = 3; i >= 0; i--) begin
      put_bit(d1[i]);
    end
    get_bit(ack);
    check_value(32'(ack), 1, "ACK slot while disabled");
    send_stop();
    expect_entry(i2c_target_pkg::AcqStart, {7'h3A, 1'b0}, 1'b1);
    expect_entry(i2c_target_pkg::AcqData, d0, 1'b1);
    check_value(acq_q.size(), 0, "entries after disable");
    target_enable = 1'b1;
    wait_clks(5);
  endtask

  initial begin
    rst_ni          = 1'b0;
    scl_h           = 1'b1;
    sda_h           = 1'b1;
    target_enable   = 1'b1;
    addr_cfg.addr0  = 7'h3A;
    addr_cfg.mask0  = 7'h7F;
    addr_cfg.addr1  = 7'h50;
    addr_cfg.mask1  = 7'h7C;
    thd_dat         = `I2C_HOLD_W'(3);
    tx_valid        = 1'b0;
    tx_data         = '0;
    rng_state       = 32'h9c1c_e649;
    clear_counts();
    wait_clks(3);
    rst_ni = 1'b1;
    wait_clks(1);
    check_value(32'(sda_o), 1, "sda_o after reset");
    check_value(32'(target_idle), 1, "idle after reset");
    check_value(32'(acq_valid), 0, "acq_valid after reset");
    check_value(32'(tx_pop), 0, "tx_pop after reset");
    check_value(32'(cmd_complete), 0, "cmd_complete after reset");
    check_value(32'(unexp_stop), 0, "unexp_stop after reset");
    check_value(32'(sr_p_cond), 0, "sr_p_cond after reset");
    write_to_addr0();
    masked_match_restart();
    addr_mismatch();
    read_two_bytes();
    read_empty_unexp_stop();
    disable_mid_write();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
i2c_target_pkg.sv
i2c_bus_monitor.sv
i2c_byte_shifter.sv
i2c_target_fsm.sv
i2c_target_top.sv
tb_i2c_target.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_target
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
